// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --assert
TOP       = aes256_tb
FILELIST  = all.f

.PHONY: sim clean

# Pass only if the run prints the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | awk '{ print } /TEST PASS/ { found = 1 } END { exit !found }'

clean:
	rm -rf obj_dir

// ==== all.f ====
+incdir+include
logic/aes_types_pkg.sv
logic/aes_tables_pkg.sv
logic/aes_round.sv
logic/aes_key_step.sv
logic/aes_stage.sv
logic/aes256_pipeline.sv
dv/aes256_tb.sv

// ==== include/aes_tb_vectors.svh ====
`ifndef AES_TB_VECTORS_SVH
`define AES_TB_VECTORS_SVH

localparam int vec_count = 6;

// FIPS-197 C.3, then SP 800-38A F.1.5 blocks 1 to 4, then zero key on a zero block
localparam aes_types_pkg::key_t vec_key [vec_count] = '{
    256'h000102030405060708090a0b0c0d0e0f_101112131415161718191a1b1c1d1e1f,
    256'h603deb1015ca71be2b73aef0857d7781_1f352c073b6108d72d9810a30914dff4,
    256'h603deb1015ca71be2b73aef0857d7781_1f352c073b6108d72d9810a30914dff4,
    256'h603deb1015ca71be2b73aef0857d7781_1f352c073b6108d72d9810a30914dff4,
    256'h603deb1015ca71be2b73aef0857d7781_1f352c073b6108d72d9810a30914dff4,
    256'h00000000000000000000000000000000_00000000000000000000000000000000
};

localparam aes_types_pkg::block_t vec_plaintext [vec_count] = '{
    128'h00112233445566778899aabbccddeeff,
    128'h6bc1bee22e409f96e93d7e117393172a,
    128'hae2d8a571e03ac9c9eb76fac45af8e51,
    128'h30c81c46a35ce411e5fbc1191a0a52ef,
    128'hf69f2445df4f9b17ad2b417be66c3710,
    128'h00000000000000000000000000000000
};

localparam aes_types_pkg::block_t vec_ciphertext [vec_count] = '{
    128'h8ea2b7ca516745bfeafc49904b496089,
    128'hf3eed1bdb5d2a03c064b5a7e3db181f8,
    128'h591ccb10d410ed26dc5ba74a31362870,
    128'hb6ed21b99ca6f4f9f153e7b1beafed1d,
    128'h23304b7a39f9f3ff067d8d8f9e24ecc7,
    128'hdc95c078a2408989ad48a21492842087
};

`endif

// ==== dv/aes256_tb.sv ====
`timescale 1ns/1ps

module aes256_tb;

    `include "aes_tb_vectors.svh"

    // Table walks over all phases, rounded up
    localparam int table_passes = 8;
    localparam int watchdog_cycles =
        table_passes * vec_count * 4 + aes_types_pkg::pipe_latency + 50;

    // Keys alternate between the FIPS/zero entries and the SP 800-38A entries
    localparam int burst_len = 8;
    localparam int burst_order [burst_len] = '{0, 1, 5, 2, 0, 3, 5, 4};

    localparam int irregular_passes = 2;

    logic                  clk;
    logic                  reset;
    logic                  in_valid;
    aes_types_pkg::block_t plaintext;
    aes_types_pkg::key_t   key;
    logic                  out_valid;
    aes_types_pkg::block_t ciphertext;

    int cycle = 0;
    int out_count = 0;
    logic [31:0] rng_state = 32'd11;

    // Expected results and the cycle each block was accepted
    aes_types_pkg::block_t expected_q [$];
    int sent_q [$];

    aes_types_pkg::block_t popped_expected;
    int popped_sent;

    aes256_pipeline UUT (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .plaintext (plaintext),
        .key       (key),
        .out_valid (out_valid),
        .ciphertext(ciphertext)
    );

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        in_valid = 1'b0;
        plaintext = '0;
        key = '0;
    end

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic stop_on_failure();
        $display("TEST FAIL");
        $fatal(1, "stopping at the first failure");
    endtask

    task automatic check_value(input logic [127:0] actual, input logic [127:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("[ERROR] %0t: %s mismatch, got %h expected %h",
                     $time, what, actual, expected);
            stop_on_failure();
        end
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] value);
        logic [31:0] x;
        x = value;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Block is accepted on the edge after the drive
    task automatic send_entry(input int idx);
        @(posedge clk);
        #1;
        in_valid = 1'b1;
        plaintext = vec_plaintext[idx];
        key = vec_key[idx];
        expected_q.push_back(vec_ciphertext[idx]);
        sent_q.push_back(cycle + 1);
    endtask

    task automatic go_idle();
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    // Gives up a few cycles past the pipeline latency
    // A few spare cycles catch any stray out_valid
    task automatic wait_for_drain();
        int waited;
        waited = 0;
        while (expected_q.size() != 0 && waited < aes_types_pkg::pipe_latency + 5) begin
            @(posedge clk);
            waited++;
        end
        repeat (3) @(posedge clk);
    endtask

    // Expects reset already driven high; holds it for 10 edges
    task automatic hold_reset();
        for (int n = 0; n < 10; n++) begin
            @(posedge clk);
            #1;
            if (n == 0) begin
                expected_q.delete();
                sent_q.delete();
            end
            check_value(128'(out_valid), 128'(1'b0), "out_valid during reset");
        end
        reset = 1'b0;
    endtask

    // Outputs are stable at the falling edge
    always @(negedge clk) begin
        if (!reset && $isunknown(out_valid)) begin
            $display("out_valid is unknown while reset is low");
            stop_on_failure();
        end else if (out_valid === 1'b1) begin
            if (expected_q.size() == 0) begin
                $display("out_valid went high with no block in flight");
                stop_on_failure();
            end else begin
                popped_expected = expected_q.pop_front();
                popped_sent = sent_q.pop_front();
                check_value(ciphertext, popped_expected, "ciphertext");
                // Downstream logic takes the result on the next rising edge
                check_value(128'(cycle + 1 - popped_sent),
                            128'(aes_types_pkg::pipe_latency), "latency in cycles");
                out_count++;
            end
        end
    end

    initial begin : watchdog
        repeat (watchdog_cycles) @(posedge clk);
        $display("Timeout: run did not finish within %0d cycles", watchdog_cycles);
        stop_on_failure();
    end

    initial begin : stimulus
        int count_before;
        int gap;

        hold_reset();

        // Single block alone
        count_before = out_count;
        send_entry(0);
        go_idle();
        wait_for_drain();
        check_value(128'(out_count - count_before), 128'(1), "outputs for a single block");

        // Back to back with the key changing every cycle
        count_before = out_count;
        for (int i = 0; i < burst_len; i++) begin
            send_entry(burst_order[i]);
        end
        go_idle();
        wait_for_drain();
        check_value(128'(out_count - count_before), 128'(burst_len),
                    "outputs for full-rate burst");

        // Random idle gaps of 0 to 3 cycles
        count_before = out_count;
        for (int p = 0; p < irregular_passes; p++) begin
            for (int i = 0; i < vec_count; i++) begin
                send_entry(i);
                rng_state = xorshift(rng_state);
                gap = int'(rng_state[1:0]);
                repeat (gap) go_idle();
            end
        end
        go_idle();
        wait_for_drain();
        check_value(128'(out_count - count_before), 128'(irregular_passes * vec_count),
                    "outputs for irregular arrival");

        // Reset while the pipeline is full
        for (int i = 0; i < vec_count; i++) begin
            send_entry(i);
        end
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        reset = 1'b1;
        hold_reset();

        count_before = out_count;
        for (int i = 0; i < vec_count; i++) begin
            send_entry(i);
        end
        go_idle();
        wait_for_drain();
        check_value(128'(out_count - count_before), 128'(vec_count), "outputs after reset");

        if (expected_q.size() == 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            $display("Blocks still expected at the end of the run: %0d", expected_q.size());
            stop_on_failure();
        end
    end

endmodule

// ==== logic/aes256_pipeline.sv ====
`timescale 1ns/1ps

module aes256_pipeline (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  in_valid,
    input  aes_types_pkg::block_t plaintext,
    input  aes_types_pkg::key_t   key,
    output logic                  out_valid,
    output aes_types_pkg::block_t ciphertext
);

    // Round 0 register
    logic                  valid_r0;
    aes_types_pkg::block_t state_r0;
    aes_types_pkg::key_t   window_r0;

    // Index r holds the outputs of stage r, index 0 the round-0 register
    logic                  valid_pipe  [0:aes_types_pkg::num_rounds];
    aes_types_pkg::block_t state_pipe  [0:aes_types_pkg::num_rounds];
    aes_types_pkg::key_t   window_pipe [0:aes_types_pkg::num_rounds];

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_r0 <= 1'b0;
        end else begin
            valid_r0 <= in_valid;
        end
    end

    // Round key 0 is the upper half of the cipher key
    always_ff @(posedge clk) begin
        state_r0 <= plaintext ^ key[aes_types_pkg::key_width-1 -: aes_types_pkg::block_width];
        window_r0 <= key;
    end

    assign valid_pipe[0] = valid_r0;
    assign state_pipe[0] = state_r0;
    assign window_pipe[0] = window_r0;

    for (genvar r = 1; r <= aes_types_pkg::num_rounds; r++) begin : g_stage
        aes_stage #(
            .round(r)
        ) u_stage (
            .clk       (clk),
            .reset     (reset),
            .valid_in  (valid_pipe[r-1]),
            .state_in  (state_pipe[r-1]),
            .window_in (window_pipe[r-1]),
            .valid_out (valid_pipe[r]),
            .state_out (state_pipe[r]),
            .window_out(window_pipe[r])
        );
    end

    assign out_valid = valid_pipe[aes_types_pkg::num_rounds];
    assign ciphertext = state_pipe[aes_types_pkg::num_rounds];

    // Fixed latency end to end, once reset has stayed low long enough
    a_latency: assert property (
        @(posedge clk)
        (!reset) [*aes_types_pkg::pipe_latency + 1]
        |-> out_valid == $past(in_valid, aes_types_pkg::pipe_latency)
    ) else $error("out_valid does not follow in_valid by %0d cycles",
                  aes_types_pkg::pipe_latency);

endmodule

// ==== logic/aes_key_step.sv ====
`timescale 1ns/1ps

module aes_key_step #(
    parameter int step = 1
) (
    input  aes_types_pkg::key_t window_in,
    output aes_types_pkg::key_t window_out
);

    localparam bit rotate_step = (step % 2) == 1;

    aes_types_pkg::word_t last_word;
    aes_types_pkg::word_t rotated;
    aes_types_pkg::word_t substituted;
    aes_types_pkg::word_t first_temp;
    aes_types_pkg::word_t new_words [4];

    assign last_word = window_in[aes_types_pkg::word_width-1:0];

    // RotWord on odd steps only
    assign rotated = rotate_step ? {last_word[23:0], last_word[31:24]} : last_word;

    // SubWord
    always_comb begin
        for (int b = 0; b < 4; b++) begin
            substituted[31-8*b -: 8] = aes_tables_pkg::sbox(rotated[31-8*b -: 8]);
        end
    end

    assign first_temp = rotate_step
                      ? substituted ^ {aes_tables_pkg::rcon((step + 1) / 2), 24'h000000}
                      : substituted;

    // Each new word also folds in the matching word eight back
    always_comb begin
        new_words[0] = window_in[aes_types_pkg::key_width-1 -: 32] ^ first_temp;
        for (int j = 1; j < 4; j++) begin
            new_words[j] = new_words[j-1] ^ window_in[aes_types_pkg::key_width-1-32*j -: 32];
        end
    end

    // Old lower half moves up, fresh round key fills the bottom
    assign window_out = {window_in[aes_types_pkg::block_width-1:0],
                         new_words[0], new_words[1], new_words[2], new_words[3]};

endmodule

// ==== logic/aes_round.sv ====
`timescale 1ns/1ps

module aes_round #(
    parameter bit final_round = 1'b0
) (
    input  aes_types_pkg::block_t state_in,
    input  aes_types_pkg::block_t round_key,
    output aes_types_pkg::block_t state_out
);

    // Byte i is row i%4, column i/4; byte 0 sits in the top bits
    aes_types_pkg::byte_t subbed [16];
    aes_types_pkg::byte_t shifted [16];
    aes_types_pkg::byte_t doubled [16];
    aes_types_pkg::byte_t mixed [16];
    aes_types_pkg::block_t round_data;

    // SubBytes
    always_comb begin
        for (int i = 0; i < 16; i++) begin
            subbed[i] = aes_tables_pkg::sbox(state_in[aes_types_pkg::block_width-1-8*i -: 8]);
        end
    end

    // ShiftRows, row r rotated left by r
    always_comb begin
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                shifted[r + 4*c] = subbed[r + 4*((c + r) % 4)];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < 16; i++) begin
            doubled[i] = aes_tables_pkg::xtime(shifted[i]);
        end
    end

    // MixColumns: out_k = 2*a_k ^ 3*a_k+1 ^ a_k+2 ^ a_k+3
    always_comb begin
        for (int c = 0; c < 4; c++) begin
            for (int k = 0; k < 4; k++) begin
                mixed[4*c + k] = doubled[4*c + k]
                               ^ doubled[4*c + (k + 1) % 4]
                               ^ shifted[4*c + (k + 1) % 4]
                               ^ shifted[4*c + (k + 2) % 4]
                               ^ shifted[4*c + (k + 3) % 4];
            end
        end
    end

    // Last round skips the column mix
    always_comb begin
        for (int i = 0; i < 16; i++) begin
            round_data[aes_types_pkg::block_width-1-8*i -: 8] = final_round ? shifted[i]
                                                                             : mixed[i];
        end
    end

    // AddRoundKey
    assign state_out = round_data ^ round_key;

endmodule

// ==== logic/aes_stage.sv ====
`timescale 1ns/1ps

module aes_stage #(
    parameter int round = 1
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  valid_in,
    input  aes_types_pkg::block_t state_in,
    input  aes_types_pkg::key_t   window_in,
    output logic                  valid_out,
    output aes_types_pkg::block_t state_out,
    output aes_types_pkg::key_t   window_out
);

    aes_types_pkg::block_t round_result;
    aes_types_pkg::key_t   next_window;

    // Round key is the lower half of the window
    aes_round #(
        .final_round(round == aes_types_pkg::num_rounds)
    ) u_round (
        .state_in (state_in),
        .round_key(window_in[aes_types_pkg::block_width-1:0]),
        .state_out(round_result)
    );

    if (round < aes_types_pkg::num_rounds) begin : g_key_step
        aes_key_step #(
            .step(round)
        ) u_key_step (
            .window_in (window_in),
            .window_out(next_window)
        );
    end else begin : g_last_window
        // Schedule is exhausted after the last round
        assign next_window = window_in;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_out <= 1'b0;
        end else begin
            valid_out <= valid_in;
        end
    end

    always_ff @(posedge clk) begin
        state_out <= round_result;
        window_out <= next_window;
    end

    a_valid_cleared: assert property (@(posedge clk) reset |=> !valid_out)
        else $error("stage %0d valid still high after reset", round);

    // Upstream stages must hand over a fully defined state with every valid block
    a_state_known: assert property (@(posedge clk) valid_out |-> !$isunknown(state_out))
        else $error("stage %0d holds unknown state bits on a valid block", round);

endmodule

// ==== logic/aes_tables_pkg.sv ====
package aes_tables_pkg;

    // Forward S-box, indexed by the input byte
    localparam aes_types_pkg::byte_t sbox_table [256] = '{
        8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
        8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
        8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
        8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
        8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
        8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
        8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
        8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
        8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
        8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
        8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
        8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
        8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
        8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
        8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
        8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
        8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
        8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
        8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
        8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
        8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
        8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
        8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
        8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
        8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
        8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
        8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
        8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
        8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
        8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
        8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
        8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
    };

    function automatic aes_types_pkg::byte_t sbox(input aes_types_pkg::byte_t value);
        return sbox_table[value];
    endfunction

    // Powers of two in GF(2^8), one per AES-256 rotate step
    function automatic aes_types_pkg::byte_t rcon(input int index);
        aes_types_pkg::byte_t result;
        case (index)
            1: result = 8'h01;
            2: result = 8'h02;
            3: result = 8'h04;
            4: result = 8'h08;
            5: result = 8'h10;
            6: result = 8'h20;
            7: result = 8'h40;
            default: result = 8'h00;
        endcase
        return result;
    endfunction

    // Multiply by x, reduced by the AES polynomial
    function automatic aes_types_pkg::byte_t xtime(input aes_types_pkg::byte_t value);
        aes_types_pkg::byte_t shifted;
        shifted = {value[6:0], 1'b0};
        return value[7] ? (shifted ^ 8'h1b) : shifted;
    endfunction

endpackage

// ==== logic/aes_types_pkg.sv ====
package aes_types_pkg;

    // Cipher geometry
    localparam int byte_width = 8;
    localparam int word_width = 32;
    localparam int block_width = 128;
    localparam int key_width = 256;

    // AES-256 round count
    localparam int num_rounds = 14;

    // Input register plus one register per round
    localparam int pipe_latency = num_rounds + 1;

    // State block or one round key
    typedef logic [block_width-1:0] block_t;

    // Cipher key or the two-round-key window of the schedule
    typedef logic [key_width-1:0] key_t;

    // State column or schedule word
    typedef logic [word_width-1:0] word_t;

    // Single state byte
    typedef logic [byte_width-1:0] byte_t;

endpackage
